// File: logic/coreDataPkg.sv
package coreDataPkg;

	// datapath and register file sizes.
	localparam int wordBits    = 16;
	localparam int regCount    = 16;
	localparam int regAddrBits = 4;

	localparam int aluFuncBits = 4; // width of an ALU function code.

	// ALU function codes.
	localparam logic [aluFuncBits-1:0] aluMove = 4'd0;  // pass operand A.
	localparam logic [aluFuncBits-1:0] aluClrC = 4'd1;
	localparam logic [aluFuncBits-1:0] aluSetC = 4'd2;
	localparam logic [aluFuncBits-1:0] aluClrZ = 4'd3;
	localparam logic [aluFuncBits-1:0] aluSetZ = 4'd4;
	localparam logic [aluFuncBits-1:0] aluClrS = 4'd5;
	localparam logic [aluFuncBits-1:0] aluSetS = 4'd6;
	localparam logic [aluFuncBits-1:0] aluAdd  = 4'd7;  // sets C, Z and S.
	localparam logic [aluFuncBits-1:0] aluSub  = 4'd8;  // C holds the borrow.

	// codes 9 and 10 stay reserved for multiply.

	localparam logic [aluFuncBits-1:0] aluAnd  = 4'd11; // logic ops touch Z only.
	localparam logic [aluFuncBits-1:0] aluOr   = 4'd12;
	localparam logic [aluFuncBits-1:0] aluXor  = 4'd13;

	// rotates go through the carry flag.
	localparam logic [aluFuncBits-1:0] aluRol  = 4'd14;
	localparam logic [aluFuncBits-1:0] aluRor  = 4'd15;

endpackage

// File: logic/coreIsaPkg.sv
package coreIsaPkg;

	localparam int instrBits = 16; // one instruction word.
	localparam int opBits    = 4;
	localparam int immBits   = 8;  // load-immediate payload, zero extended.

	// field positions inside the instruction word.
	localparam int opHi   = 15;
	localparam int opLo   = 12;
	localparam int dstHi  = 11;
	localparam int dstLo  = 8;
	localparam int srcAHi = 7;
	localparam int srcALo = 4;
	localparam int srcBHi = 3;
	localparam int srcBLo = 0;

	// the immediate overlaps both source fields.
	localparam int immHi  = 7;
	localparam int immLo  = 0;

	// opcodes.
	localparam logic [opBits-1:0] opMov  = 4'd0;
	localparam logic [opBits-1:0] opClrC = 4'd1;
	localparam logic [opBits-1:0] opSetC = 4'd2;
	localparam logic [opBits-1:0] opClrZ = 4'd3;
	localparam logic [opBits-1:0] opSetZ = 4'd4;
	localparam logic [opBits-1:0] opClrS = 4'd5;
	localparam logic [opBits-1:0] opSetS = 4'd6;
	localparam logic [opBits-1:0] opAdd  = 4'd7;
	localparam logic [opBits-1:0] opSub  = 4'd8;
	localparam logic [opBits-1:0] opCmp  = 4'd9;  // sub without writeback.
	localparam logic [opBits-1:0] opLdi  = 4'd10; // move of the immediate.
	localparam logic [opBits-1:0] opAnd  = 4'd11;
	localparam logic [opBits-1:0] opOr   = 4'd12;
	localparam logic [opBits-1:0] opXor  = 4'd13;
	localparam logic [opBits-1:0] opRol  = 4'd14;
	localparam logic [opBits-1:0] opRor  = 4'd15;

	// decoded writeback control.
	localparam logic writeNone   = 1'b0;
	localparam logic writeResult = 1'b1;

endpackage

// File: logic/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic                                CLK,
	input  logic                                RSTb,
	input  logic [coreDataPkg::regAddrBits-1:0] rdAddrA,
	input  logic [coreDataPkg::regAddrBits-1:0] rdAddrB,
	input  logic                                wrEn,
	input  logic [coreDataPkg::regAddrBits-1:0] wrAddr,
	input  logic [coreDataPkg::wordBits-1:0]    wrData,
	output logic [coreDataPkg::wordBits-1:0]    rdDataA,
	output logic [coreDataPkg::wordBits-1:0]    rdDataB
);
	import coreDataPkg::*;

	logic [wordBits-1:0] regs [regCount];

	// all registers read zero after reset.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// two asynchronous read ports.
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB]; // same-cycle writes are handled by the bypass.

endmodule

// File: logic/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
	input  logic                                CLK,
	input  logic                                RSTb,
	input  logic [coreIsaPkg::instrBits-1:0]    instr,
	input  logic                                instrValid,
	output logic [coreDataPkg::regAddrBits-1:0] rdAddrA,
	output logic [coreDataPkg::regAddrBits-1:0] rdAddrB,
	input  logic [coreDataPkg::wordBits-1:0]    rdDataA,
	input  logic [coreDataPkg::wordBits-1:0]    rdDataB,
	input  logic                                wrEn,
	input  logic [coreDataPkg::regAddrBits-1:0] wrAddr,
	input  logic [coreDataPkg::wordBits-1:0]    wrData,
	output logic [coreDataPkg::wordBits-1:0]    opA,
	output logic [coreDataPkg::wordBits-1:0]    opB,
	output logic [coreDataPkg::aluFuncBits-1:0] aluFunc,
	output logic [coreDataPkg::regAddrBits-1:0] execDest,
	output logic                                execWrite,
	output logic                                execValid
);
	import coreDataPkg::*;
	import coreIsaPkg::*;

	logic [opBits-1:0]      opcode;
	logic [aluFuncBits-1:0] funcNext;
	logic                   writeNext;
	logic                   immSel;   // operand A comes from the immediate.
	logic [wordBits-1:0]    immWord;
	logic                   bypassA;
	logic                   bypassB;

	assign opcode = instr[opHi:opLo];

	// opcode to ALU function and writeback.
	always_comb begin
		funcNext  = aluMove;
		writeNext = writeResult;
		case (opcode)
			opMov:  funcNext = aluMove;
			opLdi:  funcNext = aluMove; // immediate is steered onto operand A.
			opAdd:  funcNext = aluAdd;
			opSub:  funcNext = aluSub;
			opCmp: begin
				funcNext  = aluSub;
				writeNext = writeNone;  // flags only.
			end
			opAnd:  funcNext = aluAnd;
			opOr:   funcNext = aluOr;
			opXor:  funcNext = aluXor;
			opRol:  funcNext = aluRol;
			opRor:  funcNext = aluRor;
			default: begin
				// the six flag instructions map one to one onto ALU codes 1 to 6.
				funcNext  = opcode;
				writeNext = writeNone;
			end
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			execValid <= 1'b0;
			execWrite <= writeNone;
			aluFunc   <= aluMove;
			immSel    <= 1'b0;
		end else begin
			execValid <= instrValid;
			if (instrValid) begin
				execWrite <= writeNext;
				aluFunc   <= funcNext;
				immSel    <= (opcode == opLdi);
			end
		end
	end

	// register fields and immediate.
	always_ff @(posedge CLK) begin
		if (instrValid) begin
			execDest <= instr[dstHi:dstLo];
			rdAddrA  <= instr[srcAHi:srcALo];
			rdAddrB  <= instr[srcBHi:srcBLo];
			immWord  <= {{(wordBits-immBits){1'b0}}, instr[immHi:immLo]};
		end
	end

	// the register file is read in the execute cycle, so the previous instruction's
	// result is still sitting on the write port and must be taken from there.
	assign bypassA = wrEn && (wrAddr == rdAddrA);
	assign bypassB = wrEn && (wrAddr == rdAddrB);

	assign opA = immSel ? immWord : (bypassA ? wrData : rdDataA);
	assign opB = bypassB ? wrData : rdDataB;

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic                                CLK,
	input  logic                                RSTb,
	input  logic [coreDataPkg::wordBits-1:0]    opA,
	input  logic [coreDataPkg::wordBits-1:0]    opB,
	input  logic [coreDataPkg::aluFuncBits-1:0] aluFunc,
	input  logic                                execValid,
	output logic [coreDataPkg::wordBits-1:0]    aluOut,
	output logic                                C,  // carry.
	output logic                                Z,  // zero.
	output logic                                S   // sign.
);
	import coreDataPkg::*;

	logic [wordBits:0]   sum;   // extra bit is the carry out.
	logic [wordBits:0]   diff;  // extra bit is the borrow.
	logic [wordBits-1:0] andWord;
	logic [wordBits-1:0] orWord;
	logic [wordBits-1:0] xorWord;
	logic [wordBits-1:0] rolWord;
	logic [wordBits-1:0] rorWord;
	logic                cNext;
	logic                zNext;
	logic                sNext;

	assign sum  = {1'b0, opA} + {1'b0, opB};
	assign diff = {1'b0, opA} - {1'b0, opB};

	assign andWord = opA & opB;
	assign orWord  = opA | opB;
	assign xorWord = opA ^ opB;

	// rotate through carry.
	assign rolWord = {opA[wordBits-2:0], C};
	assign rorWord = {C, opA[wordBits-1:1]};

	always_comb begin
		// flags hold unless the function names them.
		cNext  = C;
		zNext  = Z;
		sNext  = S;
		aluOut = '0;
		case (aluFunc)
			aluMove: aluOut = opA;
			aluClrC: cNext = 1'b0;
			aluSetC: cNext = 1'b1;
			aluClrZ: zNext = 1'b0;
			aluSetZ: zNext = 1'b1;
			aluClrS: sNext = 1'b0;
			aluSetS: sNext = 1'b1;
			aluAdd: begin
				aluOut = sum[wordBits-1:0];
				cNext  = sum[wordBits];
				zNext  = ~|aluOut;
				sNext  = aluOut[wordBits-1];
			end
			aluSub: begin
				aluOut = diff[wordBits-1:0];
				cNext  = diff[wordBits];
				zNext  = ~|aluOut;
				sNext  = aluOut[wordBits-1];
			end
			aluAnd: begin
				aluOut = andWord;
				zNext  = ~|aluOut;
			end
			aluOr: begin
				aluOut = orWord;
				zNext  = ~|aluOut;
			end
			aluXor: begin
				aluOut = xorWord;
				zNext  = ~|aluOut;
			end
			aluRol: begin
				aluOut = rolWord;
				cNext  = opA[wordBits-1]; // msb falls out into carry.
			end
			aluRor: begin
				aluOut = rorWord;
				cNext  = opA[0];
			end
			default: aluOut = '0; // multiply codes, never issued.
		endcase
	end

	// flags move only for an instruction in execute.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			C <= 1'b0;
			Z <= 1'b0;
			S <= 1'b0;
		end else if (execValid) begin
			C <= cNext;
			Z <= zNext;
			S <= sNext;
		end
	end

endmodule

// File: logic/resultWrite.sv
`timescale 1ns/1ps

module resultWrite (
	input  logic                                CLK,
	input  logic                                RSTb,
	input  logic [coreDataPkg::wordBits-1:0]    aluOut,
	input  logic                                execValid,
	input  logic [coreDataPkg::regAddrBits-1:0] execDest,
	input  logic                                execWrite,
	output logic                                wrEn,
	output logic [coreDataPkg::regAddrBits-1:0] wrAddr,
	output logic [coreDataPkg::wordBits-1:0]    wrData,
	output logic [coreDataPkg::wordBits-1:0]    result,
	output logic [coreDataPkg::regAddrBits-1:0] resultReg,
	output logic                                resultValid
);
	logic writeback; // instruction in execute has a destination.

	assign writeback = execValid && execWrite;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			wrEn <= 1'b0;
		end else begin
			wrEn <= writeback;
		end
	end

	// result register, loaded only for writing instructions.
	always_ff @(posedge CLK) begin
		if (writeback) begin
			wrData <= aluOut;
			wrAddr <= execDest;
		end
	end

	// the same register feeds the register file, the bypass and the core outputs.
	assign result      = wrData;
	assign resultReg   = wrAddr;
	assign resultValid = wrEn;    // one pulse per writeback.

endmodule

// File: logic/execCore.sv
`timescale 1ns/1ps

module execCore (
	input  logic                                CLK,
	input  logic                                RSTb,
	input  logic [coreIsaPkg::instrBits-1:0]    instr,
	input  logic                                instrValid,
	output logic [coreDataPkg::wordBits-1:0]    result,
	output logic [coreDataPkg::regAddrBits-1:0] resultReg,
	output logic                                resultValid,
	output logic                                C,
	output logic                                Z,
	output logic                                S
);
	import coreDataPkg::*;

	// register file ports.
	logic [regAddrBits-1:0] rdAddrA;
	logic [regAddrBits-1:0] rdAddrB;
	logic [wordBits-1:0]    rdDataA;
	logic [wordBits-1:0]    rdDataB;
	logic                   wrEn;
	logic [regAddrBits-1:0] wrAddr;
	logic [wordBits-1:0]    wrData;

	// execute stage.
	logic [wordBits-1:0]    opA;
	logic [wordBits-1:0]    opB;
	logic [aluFuncBits-1:0] aluFunc;
	logic [regAddrBits-1:0] execDest;
	logic                   execWrite;
	logic                   execValid;
	logic [wordBits-1:0]    aluOut;

	instrDecode decode (
		.CLK(CLK), .RSTb(RSTb),
		.instr(instr), .instrValid(instrValid),
		.rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
		.rdDataA(rdDataA), .rdDataB(rdDataB),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.opA(opA), .opB(opB), .aluFunc(aluFunc),
		.execDest(execDest), .execWrite(execWrite), .execValid(execValid)
	);

	regFile regs (
		.CLK(CLK), .RSTb(RSTb),
		.rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.rdDataA(rdDataA), .rdDataB(rdDataB)
	);

	alu execUnit (
		.CLK(CLK), .RSTb(RSTb),
		.opA(opA), .opB(opB), .aluFunc(aluFunc), .execValid(execValid),
		.aluOut(aluOut), .C(C), .Z(Z), .S(S)
	);

	resultWrite writeStage (
		.CLK(CLK), .RSTb(RSTb),
		.aluOut(aluOut), .execValid(execValid),
		.execDest(execDest), .execWrite(execWrite),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.result(result), .resultReg(resultReg), .resultValid(resultValid)
	);

endmodule

// File: sim/execCore_checker.sv
`timescale 1ns/1ps

module execCore_checker (
	input logic                             CLK,
	input logic                             RSTb,
	input logic [coreIsaPkg::instrBits-1:0] instr,
	input logic                             instrValid,
	input logic                             resultValid,
	input logic                             C,
	input logic                             Z,
	input logic                             S
);
	import coreIsaPkg::*;

	logic flagsOnly; // compare and the six flag instructions.
	logic writing;
	int   failures;  // assertion failures seen so far.

	assign flagsOnly = instr[opHi:opLo] inside {opClrC, opSetC, opClrZ, opSetZ,
		opClrS, opSetS, opCmp};
	assign writing   = instrValid && !flagsOnly;

	// decode, execute, then writeback.
	writeLatency: assert property (@(posedge CLK) disable iff (!RSTb)
		writing |-> ##2 resultValid)
		else begin
			failures++;
			$error("resultValid missing two cycles after a writing instruction");
		end

	noWriteForFlags: assert property (@(posedge CLK) disable iff (!RSTb)
		instrValid && flagsOnly |-> ##2 !resultValid)
		else begin
			failures++;
			$error("resultValid raised by a compare or flag instruction");
		end

	// quiet through reset and on the first cycle out of it.
	quietInReset: assert property (@(posedge CLK) !RSTb |=> !resultValid)
		else begin
			failures++;
			$error("resultValid high during reset");
		end

	quietAfterReset: assert property (@(posedge CLK) $rose(RSTb) |=> !resultValid)
		else begin
			failures++;
			$error("resultValid high on the first cycle after reset");
		end

	flagsKnown: assert property (@(posedge CLK) RSTb |-> !$isunknown({C, Z, S}))
		else begin
			failures++;
			$error("carry, zero or sign flag is unknown after reset");
		end

endmodule

bind execCore execCore_checker resultCheck (
	.CLK(CLK), .RSTb(RSTb), .instr(instr), .instrValid(instrValid),
	.resultValid(resultValid), .C(C), .Z(Z), .S(S)
);

// File: sim/execCoreTb.sv
`timescale 1ns/1ps

module execCoreTb;
	import coreDataPkg::*;
	import coreIsaPkg::*;

	localparam int drainLimit  = 20;  // cycles for the pipeline to empty.
	localparam int randomCount = 300;

	// expected outcome of one issued instruction.
	typedef struct packed {
		int                     cycle;  // tick at which it was driven.
		logic                   write;
		logic [regAddrBits-1:0] dest;
		logic [wordBits-1:0]    data;
		logic [2:0]             flags;  // {C, Z, S} once executed.
	} slotT;

	logic                   CLK;
	logic                   RSTb;
	logic [instrBits-1:0]   instr;
	logic                   instrValid;
	logic [wordBits-1:0]    result;
	logic [regAddrBits-1:0] resultReg;
	logic                   resultValid;
	logic                   C;
	logic                   Z;
	logic                   S;

	slotT                   pending[$];
	logic [wordBits-1:0]    model [regCount]; // reference registers.
	logic                   mC;
	logic                   mZ;
	logic                   mS;
	int                     cycle;
	int                     checks;
	int                     errors;

	execCore UUT (
		.CLK(CLK), .RSTb(RSTb), .instr(instr), .instrValid(instrValid),
		.result(result), .resultReg(resultReg), .resultValid(resultValid),
		.C(C), .Z(Z), .S(S)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	function automatic logic [instrBits-1:0] encode(input logic [opBits-1:0] op,
		input logic [3:0] d, input logic [3:0] a, input logic [3:0] b);
		return {op, d, a, b};
	endfunction

	function automatic logic [instrBits-1:0] loadImm(input logic [3:0] d,
		input logic [7:0] imm);
		return {opLdi, d, imm};
	endfunction

	// reference model that applies one instruction in program order.
	task automatic applyModel(input logic [instrBits-1:0] word, output slotT slot);
		logic [opBits-1:0]   op;
		logic [wordBits-1:0] a;
		logic [wordBits-1:0] b;
		logic [wordBits:0]   wide;
		op         = word[opHi:opLo];
		a          = model[word[srcAHi:srcALo]];
		b          = model[word[srcBHi:srcBLo]];
		slot       = '0;
		slot.write = 1'b1;
		slot.dest  = word[dstHi:dstLo];
		case (op)
			opMov: slot.data = a;
			opLdi: slot.data = {8'h00, word[immHi:immLo]};
			opAdd: begin
				wide      = a + b;
				slot.data = wide[wordBits-1:0];
				mC        = wide[wordBits];  // carry out.
			end
			opSub, opCmp: begin
				slot.data  = a - b;
				mC         = (a < b);        // borrow.
				slot.write = (op == opSub);
			end
			opAnd: slot.data = a & b;
			opOr:  slot.data = a | b;
			opXor: slot.data = a ^ b;
			opRol: begin
				slot.data = {a[wordBits-2:0], mC};
				mC        = a[wordBits-1];
			end
			opRor: begin
				slot.data = {mC, a[wordBits-1:1]};
				mC        = a[0];
			end
			default: slot.write = 1'b0;
		endcase
		case (op)
			opClrC: mC = 1'b0;
			opSetC: mC = 1'b1;
			opClrZ: mZ = 1'b0;
			opSetZ: mZ = 1'b1;
			opClrS: mS = 1'b0;
			opSetS: mS = 1'b1;
			opAdd, opSub, opCmp: begin
				mZ = (slot.data == 0);
				mS = slot.data[wordBits-1];
			end
			opAnd, opOr, opXor: mZ = (slot.data == 0);
			default: ;
		endcase
		if (slot.write) begin
			model[slot.dest] = slot.data;
		end
		slot.flags = {mC, mZ, mS};
	endtask

	task automatic checkSlot(input slotT slot);
		checks++;
		assert (resultValid === slot.write) else begin
			errors++;
			$display("Mismatch at %0t: resultValid %b, expected %b",
				$time, resultValid, slot.write);
		end
		assert (!slot.write || (result === slot.data && resultReg === slot.dest)) else begin
			errors++;
			$display("Mismatch at %0t: r%0d = %h, expected r%0d = %h",
				$time, resultReg, result, slot.dest, slot.data);
		end
		assert ({C, Z, S} === slot.flags) else begin
			errors++;
			$display("Mismatch at %0t: flags CZS %b, expected %b",
				$time, {C, Z, S}, slot.flags);
		end
	endtask

	// advance one falling edge and check the results due two ticks after issue.
	task automatic tick();
		@(negedge CLK);
		cycle++;
		while (pending.size() > 0 && pending[0].cycle + 2 == cycle) begin
			checkSlot(pending.pop_front());
		end
	endtask

	task automatic issue(input logic [instrBits-1:0] word);
		slotT slot;
		tick();
		instr      = word;
		instrValid = 1'b1;
		applyModel(word, slot);
		slot.cycle = cycle;
		pending.push_back(slot);
	endtask

	task automatic idle();
		tick();
		instrValid = 1'b0;
	endtask

	initial begin
		logic [instrBits-1:0] word;
		int                   guard;
		void'($urandom(32'hd8b1));
		RSTb       = 1'b0;
		instr      = '0;
		instrValid = 1'b0;
		cycle      = 0;
		checks     = 0;
		errors     = 0;
		{mC, mZ, mS} = 3'b000;
		for (int r = 0; r < regCount; r++) begin
			model[r] = '0;
		end
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		RSTb = 1'b1;

		issue(loadImm(4'd1, 8'ha5));      // immediate followed by a dependent move.
		issue(encode(opMov, 4'd2, 4'd1, 4'd0));
		issue(loadImm(4'd3, 8'hff));
		issue(loadImm(4'd4, 8'hff));
		issue(loadImm(4'd5, 8'h01));
		issue(encode(opAdd, 4'd6, 4'd4, 4'd5));
		issue(loadImm(4'd7, 8'h00));
		issue(encode(opSub, 4'd9, 4'd7, 4'd5));  // 0 - 1 borrows and goes negative.
		issue(encode(opAdd, 4'd10, 4'd9, 4'd5)); // wraps to zero with carry.
		issue(encode(opSub, 4'd11, 4'd5, 4'd5));
		issue(encode(opCmp, 4'd0, 4'd5, 4'd4));
		issue(encode(opSetC, 4'd0, 4'd0, 4'd0));
		issue(encode(opSetS, 4'd0, 4'd0, 4'd0));
		issue(encode(opAnd, 4'd12, 4'd4, 4'd5));
		issue(encode(opXor, 4'd13, 4'd4, 4'd4));
		issue(encode(opOr, 4'd14, 4'd9, 4'd5));
		issue(encode(opRol, 4'd1, 4'd9, 4'd0));
		issue(encode(opClrC, 4'd0, 4'd0, 4'd0));
		issue(encode(opRor, 4'd2, 4'd5, 4'd0));
		issue(encode(opRol, 4'd3, 4'd2, 4'd0));
		issue(encode(opRor, 4'd8, 4'd4, 4'd0));

		// two passes so that every flag instruction flips its flag at least once.
		repeat (2) begin
			for (int f = opClrC; f <= opSetS; f++) begin
				issue(encode(f[opBits-1:0], 4'd15, 4'd0, 4'd0));
				idle();
			end
		end

		// dependent random stream over four registers.
		for (int i = 0; i < randomCount; i++) begin
			word = $urandom;
			if (word[opHi:opLo] != opLdi) begin
				word[srcAHi:srcALo] = $urandom % 4;
				word[srcBHi:srcBLo] = $urandom % 4;
			end
			word[dstHi:dstLo] = $urandom % 4;
			if ($urandom % 5 == 0) begin
				idle();
			end
			issue(word);
		end

		guard = 0;
		while (pending.size() > 0 && guard < drainLimit) begin
			idle();
			guard++;
		end
		if (pending.size() > 0) begin
			errors++;
			$display("Timeout: %0d issued instructions never completed", pending.size());
		end

		errors += UUT.resultCheck.failures; // failed assertions of the bound checker.

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: vlog.f
logic/coreDataPkg.sv
logic/coreIsaPkg.sv
logic/regFile.sv
logic/instrDecode.sv
logic/alu.sv
logic/resultWrite.sv
logic/execCore.sv
sim/execCore_checker.sv
sim/execCoreTb.sv
